// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [63:0] instr_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [1:0]  half_we_t; // bit 0 low half, bit 1 high half.
	typedef logic [2:0]  flags_t;

	localparam int NUM_REGS = 16;
	localparam addr_t PC_STEP = 32'd8; // bytes per instruction.

	// flag bit positions.
	localparam int FLAG_EQ = 2;
	localparam int FLAG_LT = 1;
	localparam int FLAG_LTU = 0;

	typedef enum logic [3:0] {
		T_NOP = 4'h0,
		T_ALU = 4'h1,
		T_INT = 4'h2,
		T_LDI = 4'h3,
		T_MOV = 4'h4,
		T_CMP = 4'h5
	} instr_type_e;

	typedef enum logic [2:0] {
		ADD, SUB, AND, OR, XOR, SHL, SHR, PASSB
	} alu_op_e;

	typedef struct packed {
		reg_idx_t read1;
		reg_idx_t read2;
	} rd_sel_t;

	typedef struct packed {
		logic     valid;
		addr_t    pc;
		instr_t   ir;
		word_t    opa;
		word_t    opb;
		half_we_t reg_write;
	} id_ex_t;

	typedef struct packed {
		half_we_t we;
		reg_idx_t addr;
		word_t    data;
	} wb_t;

	// instruction field access.
	function automatic instr_type_e type_of(instr_t ir);
		return instr_type_e'(ir[31:28]);
	endfunction

	function automatic logic [3:0] op_of(instr_t ir);
		return ir[27:24];
	endfunction

	function automatic reg_idx_t ra_of(instr_t ir);
		return ir[23:20];
	endfunction

	function automatic reg_idx_t rb_of(instr_t ir);
		return ir[19:16];
	endfunction

	function automatic reg_idx_t rc_of(instr_t ir);
		return ir[15:12];
	endfunction

	function automatic word_t imm_of(instr_t ir);
		return ir[63:32];
	endfunction

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           stall_i,
	output cpu_pkg::addr_t pc_o
);
	import cpu_pkg::*;

	addr_t pc_q;

	// one instruction per cycle unless decode holds.
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			pc_q <= '0;
		else if (!stall_i)
			pc_q <= pc_q + PC_STEP;
	end

	assign pc_o = pc_q; // rom address.

endmodule

// ==== hdl/idecode.sv ====
`timescale 1ns/100ps

module idecode (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             stall_i,
	input  cpu_pkg::instr_t  ir_i,
	input  cpu_pkg::addr_t   pc_i,
	output cpu_pkg::rd_sel_t rd_sel_o,
	input  cpu_pkg::word_t   rd_data1_i,
	input  cpu_pkg::word_t   rd_data2_i,
	output cpu_pkg::id_ex_t  id_ex_o
);
	import cpu_pkg::*;

	instr_type_e ir_type;
	logic [3:0]  op_bits;
	half_we_t    reg_write;

	logic     valid_q;
	addr_t    pc_q;
	instr_t   ir_q;
	word_t    opa_q;
	word_t    opb_q;
	half_we_t reg_write_q;

	assign ir_type = type_of(ir_i);
	assign op_bits = op_of(ir_i);

	// source registers by type.
	always_comb
	begin
		case (ir_type)
			T_CMP:
			begin
				rd_sel_o.read1 = ra_of(ir_i);
				rd_sel_o.read2 = rb_of(ir_i);
			end
			T_MOV, T_INT, T_LDI:
			begin
				rd_sel_o.read1 = rb_of(ir_i);
				rd_sel_o.read2 = rb_of(ir_i);
			end
			default:
			begin
				rd_sel_o.read1 = rb_of(ir_i);
				rd_sel_o.read2 = rc_of(ir_i);
			end
		endcase
	end

	always_comb
	begin
		case (ir_type)
			T_ALU, T_INT, T_LDI: reg_write = 2'b11;
			T_MOV: reg_write = op_bits[1:0]; // partial move.
			default: reg_write = 2'b00;
		endcase
	end

	// stall inserts a bubble.
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			valid_q <= 1'b0;
		else
			valid_q <= !stall_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall_i)
		begin
			pc_q <= pc_i;
			ir_q <= ir_i;
			opa_q <= rd_data1_i;
			opb_q <= rd_data2_i;
			reg_write_q <= reg_write;
		end
	end

	assign id_ex_o = '{
		valid:     valid_q,
		pc:        pc_q,
		ir:        ir_q,
		opa:       opa_q,
		opb:       opb_q,
		reg_write: reg_write_q
	};

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/100ps

module register_file (
	input  logic             clk_i,
	input  logic             rst_i,
	input  cpu_pkg::rd_sel_t rd_sel_i,
	input  cpu_pkg::wb_t     wb_i,
	output cpu_pkg::word_t   rd_data1_o,
	output cpu_pkg::word_t   rd_data2_o
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	// old value with the enabled halves replaced.
	function automatic word_t merge_half(word_t old, wb_t wb);
		word_t res;
		res = old;
		if (wb.we[0])
			res[15:0] = wb.data[15:0];
		if (wb.we[1])
			res[31:16] = wb.data[31:16];
		return res;
	endfunction

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb_i.we != '0)
			regs[wb_i.addr] <= merge_half(regs[wb_i.addr], wb_i);
	end

	// write-first bypass.
	always_comb
	begin
		rd_data1_o = regs[rd_sel_i.read1];
		if (wb_i.addr == rd_sel_i.read1)
			rd_data1_o = merge_half(regs[rd_sel_i.read1], wb_i);
	end

	always_comb
	begin
		rd_data2_o = regs[rd_sel_i.read2];
		if (wb_i.addr == rd_sel_i.read2)
			rd_data2_o = merge_half(regs[rd_sel_i.read2], wb_i);
	end

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit (
	input  logic            clk_i,
	input  logic            rst_i,
	input  cpu_pkg::id_ex_t id_ex_i,
	output cpu_pkg::wb_t    wb_o,
	output cpu_pkg::flags_t flags_o
);
	import cpu_pkg::*;

	instr_type_e ex_type;
	logic [3:0]  op_bits;
	alu_op_e     alu_op;
	word_t       alu_b;
	word_t       alu_y;
	word_t       result;
	flags_t      cmp_flags;

	half_we_t wb_we_q;
	reg_idx_t wb_addr_q;
	word_t    wb_data_q;
	flags_t   flags_q;

	assign ex_type = type_of(id_ex_i.ir);
	assign op_bits = op_of(id_ex_i.ir);
	assign alu_op = alu_op_e'(op_bits[2:0]);

	// int uses the immediate as second operand.
	assign alu_b = (ex_type == T_INT) ? imm_of(id_ex_i.ir) : id_ex_i.opb;

	always_comb
	begin
		case (alu_op)
			ADD: alu_y = id_ex_i.opa + alu_b;
			SUB: alu_y = id_ex_i.opa - alu_b;
			AND: alu_y = id_ex_i.opa & alu_b;
			OR: alu_y = id_ex_i.opa | alu_b;
			XOR: alu_y = id_ex_i.opa ^ alu_b;
			SHL: alu_y = id_ex_i.opa << alu_b[4:0];
			SHR: alu_y = id_ex_i.opa >> alu_b[4:0]; // logical.
			default: alu_y = alu_b;
		endcase
	end

	always_comb
	begin
		case (ex_type)
			T_LDI: result = imm_of(id_ex_i.ir);
			T_MOV: result = id_ex_i.opa;
			default: result = alu_y;
		endcase
	end

	always_comb
	begin
		cmp_flags[FLAG_EQ] = (id_ex_i.opa == id_ex_i.opb);
		cmp_flags[FLAG_LT] = ($signed(id_ex_i.opa) < $signed(id_ex_i.opb));
		cmp_flags[FLAG_LTU] = (id_ex_i.opa < id_ex_i.opb);
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			wb_we_q <= '0;
			flags_q <= '0;
		end
		else
		begin
			wb_we_q <= id_ex_i.valid ? id_ex_i.reg_write : 2'b00;
			if (id_ex_i.valid && ex_type == T_CMP)
				flags_q <= cmp_flags;
		end
	end

	always_ff @(posedge clk_i)
	begin
		wb_addr_q <= ra_of(id_ex_i.ir);
		wb_data_q <= result;
	end

	assign wb_o = '{we: wb_we_q, addr: wb_addr_q, data: wb_data_q};
	assign flags_o = flags_q;

endmodule

// ==== hdl/hazard_control.sv ====
`timescale 1ns/100ps

module hazard_control (
	input  logic             clk_i,
	input  logic             rst_i,
	input  cpu_pkg::rd_sel_t rd_sel_i,
	input  cpu_pkg::id_ex_t  id_ex_i,
	output logic             stall_o
);
	import cpu_pkg::*;

	reg_idx_t ex_ra;
	logic     ex_writes;
	logic     ra_match;

	assign ex_ra = ra_of(id_ex_i.ir);
	assign ex_writes = id_ex_i.valid && (id_ex_i.reg_write != 2'b00);
	assign ra_match = (ex_ra == rd_sel_i.read1) || (ex_ra == rd_sel_i.read2);

	// the bypass covers the cycle after, so one bubble is enough.
	assign stall_o = ex_writes && ra_match;

	a_stall_single: assert property (@(posedge clk_i) disable iff (rst_i)
		stall_o |=> !stall_o);

	// decode turns the stall into a bubble at the next edge.
	a_stall_bubble: assert property (@(posedge clk_i) disable iff (rst_i)
		stall_o |=> !id_ex_i.valid);

endmodule

// ==== hdl/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core (
	input  logic              clk_i,
	input  logic              rst_i,
	output cpu_pkg::addr_t    imem_addr_o,
	input  cpu_pkg::instr_t   imem_data_i,
	output cpu_pkg::half_we_t wb_we_o,
	output cpu_pkg::reg_idx_t wb_addr_o,
	output cpu_pkg::word_t    wb_data_o,
	output cpu_pkg::flags_t   flags_o
);
	import cpu_pkg::*;

	addr_t   pc;
	logic    stall;
	rd_sel_t rd_sel;
	word_t   rd_data1;
	word_t   rd_data2;
	id_ex_t  id_ex;
	wb_t     wb;

	fetch_unit i_fetch_unit (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.stall_i (stall),
		.pc_o    (pc)
	);

	assign imem_addr_o = pc; // rom answers in the same cycle.

	idecode i_idecode (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.stall_i    (stall),
		.ir_i       (imem_data_i),
		.pc_i       (pc),
		.rd_sel_o   (rd_sel),
		.rd_data1_i (rd_data1),
		.rd_data2_i (rd_data2),
		.id_ex_o    (id_ex)
	);

	register_file i_register_file (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.rd_sel_i   (rd_sel),
		.wb_i       (wb),
		.rd_data1_o (rd_data1),
		.rd_data2_o (rd_data2)
	);

	execute_unit i_execute_unit (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.id_ex_i (id_ex),
		.wb_o    (wb),
		.flags_o (flags_o)
	);

	hazard_control i_hazard_control (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.rd_sel_i (rd_sel),
		.id_ex_i  (id_ex),
		.stall_o  (stall)
	);

	assign wb_we_o = wb.we;
	assign wb_addr_o = wb.addr;
	assign wb_data_o = wb.data;

endmodule

// ==== bench/cpu_core_tests.svh ====
task automatic nop_stepping();
	prog_q.delete();
	repeat (12)
		prog_q.push_back(instr_t'(0));
	load_program();
	compare_half_we("wb_we_o", wb_we, 2'b00);
	compare_flags("flags_o", flags, 3'b000);
	compare_addr("imem_addr_o", imem_addr, 32'd0);
	for (int i = 1; i <= 12; i++)
	begin
		@(negedge clk_i);
		compare_addr("imem_addr_o", imem_addr, addr_t'(i * 8));
	end
	drain_and_check();
endtask

task automatic alu_op_sweep();
	prog_q.delete();
	for (int r = 0; r < NUM_REGS; r++)
		prog_q.push_back(encode(T_LDI, 4'h0, reg_idx_t'(r), 4'h0, 4'h0, rand_bits(32)));
	for (int op = 0; op < 8; op++)
		prog_q.push_back(encode(T_ALU, 4'(op), reg_idx_t'(rand_bits(4)),
			reg_idx_t'(rand_bits(4)), reg_idx_t'(rand_bits(4)), '0));
	// same ops against immediates.
	for (int op = 0; op < 8; op++)
		prog_q.push_back(encode(T_INT, 4'(op), reg_idx_t'(rand_bits(4)),
			reg_idx_t'(rand_bits(4)), 4'h0, rand_bits(32)));
	run_program();
endtask

task automatic dependent_chain();
	prog_q.delete();
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd1, 4'd0, 4'd0, 32'h1357_9bdf));
	prog_q.push_back(encode(T_ALU, 4'(ADD), 4'd2, 4'd1, 4'd1, '0));
	prog_q.push_back(encode(T_INT, 4'(XOR), 4'd3, 4'd2, 4'd0, 32'h0ff0_5aa5));
	prog_q.push_back(encode(T_ALU, 4'(SUB), 4'd4, 4'd3, 4'd2, '0)); // r3 right behind its write.
	prog_q.push_back(encode(T_INT, 4'(SHR), 4'd5, 4'd3, 4'd0, 32'd7));
	run_program();
endtask

task automatic partial_moves();
	prog_q.delete();
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd4, 4'd0, 4'd0, 32'ha1b2_c3d4));
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd5, 4'd0, 4'd0, 32'h1111_2222));
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd6, 4'd0, 4'd0, 32'h3333_4444));
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd7, 4'd0, 4'd0, 32'h5555_6666));
	for (int op = 1; op < 4; op++)
		prog_q.push_back(encode(T_MOV, 4'(op), reg_idx_t'(op + 4), 4'd4, 4'd0, '0));
	prog_q.push_back(encode(T_MOV, 4'h0, 4'd8, 4'd4, 4'd0, '0)); // no halves.
	// read back through r0, still zero.
	for (int r = 5; r < 9; r++)
		prog_q.push_back(encode(T_ALU, 4'(OR), reg_idx_t'(r + 4), 4'd0, reg_idx_t'(r), '0));
	run_program();
endtask

task automatic flag_case(input word_t a, input word_t b);
	prog_q.delete();
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd1, 4'd0, 4'd0, a));
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd2, 4'd0, 4'd0, b));
	prog_q.push_back(encode(T_CMP, 4'h0, 4'd1, 4'd2, 4'd0, '0));
	run_program();
endtask

task automatic signed_unsigned_cmp();
	flag_case(32'd5, 32'd5);
	flag_case(32'hffff_fff0, 32'd10); // negative against positive.
	flag_case(32'd10, 32'hffff_fff0);
	flag_case(32'hffff_ffff, 32'd0);
	flag_case(32'd0, 32'hffff_ffff);
	flag_case(32'h8000_0000, 32'h7fff_ffff);
endtask

task automatic unused_types();
	prog_q.delete();
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd1, 4'd0, 4'd0, 32'd5));
	prog_q.push_back(encode(T_LDI, 4'h0, 4'd2, 4'd0, 4'd0, 32'd9));
	prog_q.push_back(encode(T_CMP, 4'h0, 4'd1, 4'd2, 4'd0, '0));
	// r1 against r0 would compare differently from the cmp above.
	for (int t = 6; t < 16; t++)
		prog_q.push_back(encode(4'(t), 4'(t), 4'd1, 4'd0, 4'd2, rand_bits(32)));
	// r1 keeps its load value.
	prog_q.push_back(encode(T_ALU, 4'(OR), 4'd3, 4'd0, 4'd1, '0));
	run_program();
endtask

// ==== bench/cpu_core_tb.sv ====
`timescale 1ns/100ps

module cpu_core_tb;
	import cpu_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int DRAIN_CYCLES = 8;
	localparam int PROG_INSTRS = 93; // all programs together.
	localparam int RUNS = 11;
	localparam int WATCHDOG_CYCLES = PROG_INSTRS * 4
		+ RUNS * (RESET_CYCLES + DRAIN_CYCLES + 20);
	localparam int ROM_DEPTH = 64;

	logic        clk_i;
	logic        rst_i;
	addr_t       imem_addr;
	instr_t      imem_data;
	half_we_t    wb_we;
	reg_idx_t    wb_addr;
	word_t       wb_data;
	flags_t      flags;
	instr_t      rom [ROM_DEPTH];
	int          rom_len;
	instr_t      prog_q [$];
	wb_t         exp_q [$];
	wb_t         mon_w;
	word_t       model_regs [NUM_REGS];
	flags_t      model_flags;
	logic [15:0] lfsr_state;
	int          mismatch_count;
	int          fail_count;

	cpu_core i_cpu_core (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.imem_addr_o (imem_addr),
		.imem_data_i (imem_data),
		.wb_we_o     (wb_we),
		.wb_addr_o   (wb_addr),
		.wb_data_o   (wb_data),
		.flags_o     (flags)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// combinational rom, nop past the program.
	always_comb
	begin
		if (imem_addr[31:3] < 29'(rom_len))
			imem_data = rom[imem_addr[8:3]];
		else
			imem_data = '0;
	end

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic word_t rand_bits(int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit.
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic instr_t encode(logic [3:0] typ, logic [3:0] op, reg_idx_t ra,
		reg_idx_t rb, reg_idx_t rc, word_t imm);
		return {imm, typ, op, ra, rb, rc, 12'h000};
	endfunction

	function automatic word_t alu_ref(logic [2:0] op, word_t a, word_t b);
		word_t y;
		case (alu_op_e'(op))
			ADD: y = a + b;
			SUB: y = a - b;
			AND: y = a & b;
			OR: y = a | b;
			XOR: y = a ^ b;
			SHL: y = a << b[4:0];
			SHR: y = a >> b[4:0];
			default: y = b;
		endcase
		return y;
	endfunction

	// one instruction on the register and flag model.
	function automatic void model_step(instr_t ir);
		logic [3:0] op;
		reg_idx_t   ra;
		reg_idx_t   rb;
		reg_idx_t   rc;
		word_t      imm;
		wb_t        w;
		op = ir[27:24];
		ra = ir[23:20];
		rb = ir[19:16];
		rc = ir[15:12];
		imm = ir[63:32];
		w = '{we: 2'b00, addr: ra, data: '0};
		case (ir[31:28])
			T_ALU:
			begin
				w.we = 2'b11;
				w.data = alu_ref(op[2:0], model_regs[rb], model_regs[rc]);
			end
			T_INT:
			begin
				w.we = 2'b11;
				w.data = alu_ref(op[2:0], model_regs[rb], imm);
			end
			T_LDI:
			begin
				w.we = 2'b11;
				w.data = imm;
			end
			T_MOV:
			begin
				w.we = op[1:0];
				w.data = model_regs[rb];
			end
			T_CMP: model_flags = {model_regs[ra] == model_regs[rb],
				$signed(model_regs[ra]) < $signed(model_regs[rb]),
				model_regs[ra] < model_regs[rb]};
			default: ;
		endcase
		if (w.we != 2'b00)
		begin
			if (w.we[0])
				model_regs[ra][15:0] = w.data[15:0];
			if (w.we[1])
				model_regs[ra][31:16] = w.data[31:16];
			exp_q.push_back(w);
		end
	endfunction

	task automatic compare_half_we(input string name, input half_we_t got, input half_we_t exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compare_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_flags(input string name, input flags_t got, input flags_t exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// each strobe takes the oldest expected write.
	always @(negedge clk_i)
	begin
		if (!rst_i && wb_we != 2'b00)
		begin
			if (exp_q.size() == 0)
			begin
				fail_count++;
				$display("unexpected write strobe to r%0d at %0t", wb_addr, $time);
			end
			else
			begin
				mon_w = exp_q.pop_front();
				compare_half_we("wb_we_o", wb_we, mon_w.we);
				compare_reg_idx("wb_addr_o", wb_addr, mon_w.addr);
				compare_word("wb_data_o", wb_data, mon_w.data);
			end
		end
	end

	task automatic load_program();
		@(negedge clk_i);
		rst_i = 1'b1;
		exp_q.delete();
		model_flags = '0;
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
		foreach (prog_q[i])
		begin
			model_step(prog_q[i]);
			rom[i] = prog_q[i];
		end
		rom_len = prog_q.size();
		repeat (RESET_CYCLES) @(negedge clk_i);
		rst_i = 1'b0;
	endtask

	task automatic drain_and_check();
		int limit;
		int cycles;
		limit = prog_q.size() * 4 + 16;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < limit)
		begin
			@(negedge clk_i);
			cycles++;
		end
		repeat (DRAIN_CYCLES) @(negedge clk_i); // let trailing cmp settle.
		compare_flags("flags_o", flags, model_flags);
		if (exp_q.size() != 0)
		begin
			fail_count++;
			$display("%0d expected writes never appeared by %0t", exp_q.size(), $time);
		end
	endtask

	task automatic run_program();
		load_program();
		drain_and_check();
	endtask

	`include "cpu_core_tests.svh"

	initial
	begin
		rst_i = 1'b1;
		rom_len = 0;
		lfsr_state = 16'd20236;
		mismatch_count = 0;
		fail_count = 0;
		nop_stepping();
		alu_op_sweep();
		dependent_chain();
		partial_moves();
		signed_unsigned_cmp();
		unused_types();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count + fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== cpu_core.f ====
+incdir+bench
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/idecode.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/hazard_control.sv
hdl/cpu_core.sv
bench/cpu_core_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module cpu_core -f cpu_core.f

sim:
	verilator --binary --timing --assert --top-module cpu_core_tb -f cpu_core.f
	./obj_dir/Vcpu_core_tb | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
